//--- rtl/dma_regmap_pkg.sv
// DMA control register map
package dma_regmap_pkg;

  // bus widths
  localparam int axil_addr_w = 32;
  localparam int axil_data_w = 32;

  // register index sits in addr[11:5], 32-byte stride
  localparam int reg_idx_lsb = 5;
  localparam int reg_idx_w   = 7;

  // mapped register indices
  localparam logic [reg_idx_w-1:0] reg_tlb        = 7'd2;  // tlb command words
  localparam logic [reg_idx_w-1:0] reg_dma_reads  = 7'd10; // read length counter
  localparam logic [reg_idx_w-1:0] reg_dma_writes = 7'd11; // write length counter
  localparam logic [reg_idx_w-1:0] reg_debug      = 7'd13; // round-robin stats

  // axi response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // returned on reads of unmapped indices
  localparam logic [axil_data_w-1:0] unmapped_rdata = 32'hdeadbeef;

endpackage

//--- rtl/dma_stats_pkg.sv
// DMA statistics and TLB command layout
package dma_stats_pkg;

  localparam int stat_w = 32; // statistics counter
  localparam int len_w  = 48; // length counter

  // debug register order, read round-robin
  localparam int num_debug_regs = 10;

  typedef enum logic [3:0] {
    dbg_write_cmd,
    dbg_write_word,
    dbg_write_pkg,
    dbg_write_len,    // lower 32 bits only
    dbg_read_cmd,
    dbg_read_word,
    dbg_read_pkg,
    dbg_read_len,     // lower 32 bits only
    dbg_tlb_miss,
    dbg_tlb_page_cross
  } debug_sel_e;

  // four full words plus bit 0 of the fifth
  localparam int tlb_cmd_w     = 129;
  localparam int tlb_cmd_words = 5;

endpackage

//--- rtl/axil_ctrl_fsm.sv
// AXI-lite control state machines
`timescale 1ns/1ps

module axil_ctrl_fsm (
  input  logic                                  user_clk,
  input  logic                                  user_aresetn,
  input  logic [dma_regmap_pkg::axil_addr_w-1:0] s_axil_awaddr,
  input  logic                                  s_axil_awvalid,
  output logic                                  s_axil_awready,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] s_axil_wdata,
  input  logic                                  s_axil_wvalid,
  output logic                                  s_axil_wready,
  output logic [1:0]                            s_axil_bresp,
  output logic                                  s_axil_bvalid,
  input  logic                                  s_axil_bready,
  input  logic [dma_regmap_pkg::axil_addr_w-1:0] s_axil_araddr,
  input  logic                                  s_axil_arvalid,
  output logic                                  s_axil_arready,
  output logic [dma_regmap_pkg::axil_data_w-1:0] s_axil_rdata,
  output logic [1:0]                            s_axil_rresp,
  output logic                                  s_axil_rvalid,
  input  logic                                  s_axil_rready,
  output logic                                  tlb_word_wr,
  output logic [dma_regmap_pkg::axil_data_w-1:0] tlb_wdata,
  input  logic                                  tlb_word_last,
  input  logic                                  tlb_cmd_done,
  output logic                                  reset_dma_read_length_counter,
  output logic                                  reset_dma_write_length_counter,
  output logic                                  rd_done_len_rd,
  output logic                                  rd_done_len_wr,
  output logic                                  rd_done_debug,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] len_rd_word,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] len_wr_word,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] debug_word,
  input  logic                                  debug_hit
);
  import dma_regmap_pkg::*;

  typedef enum logic [1:0] {w_idle, w_data, w_resp, w_tlb} wr_state_e;
  typedef enum logic {r_idle, r_resp} rd_state_e;

  wr_state_e             wr_state;
  rd_state_e             rd_state;
  logic [reg_idx_w-1:0]  aw_idx;    // latched write index
  logic [reg_idx_w-1:0]  ar_idx;    // latched read index
  logic                  w_fire;
  logic                  r_fire;

  assign w_fire = s_axil_wvalid && s_axil_wready;
  assign r_fire = s_axil_rvalid && s_axil_rready;

  // word goes to the packer in the same cycle as the data transfer
  assign tlb_word_wr  = w_fire && (aw_idx == reg_tlb);
  assign tlb_wdata    = s_axil_wdata;
  assign s_axil_bresp = resp_okay; // writes never fail, unmapped included

  // write side
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      wr_state                       <= w_idle;
      s_axil_awready                 <= 1'b0;
      s_axil_wready                  <= 1'b0;
      s_axil_bvalid                  <= 1'b0;
      reset_dma_read_length_counter  <= 1'b0;
      reset_dma_write_length_counter <= 1'b0;
    end else begin
      reset_dma_read_length_counter  <= 1'b0; // strobes last one cycle
      reset_dma_write_length_counter <= 1'b0;
      case (wr_state)
        w_idle: begin
          s_axil_awready <= 1'b1;
          if (s_axil_awvalid && s_axil_awready) begin
            aw_idx         <= s_axil_awaddr[reg_idx_lsb +: reg_idx_w];
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b1;
            wr_state       <= w_data;
          end
        end
        w_data: begin
          if (w_fire) begin
            s_axil_wready                  <= 1'b0;
            reset_dma_read_length_counter  <= (aw_idx == reg_dma_reads);
            reset_dma_write_length_counter <= (aw_idx == reg_dma_writes);
            if (aw_idx == reg_tlb && tlb_word_last) begin
              wr_state <= w_tlb;        // hold bresp until command taken
            end else begin
              s_axil_bvalid <= 1'b1;
              wr_state      <= w_resp;
            end
          end
        end
        w_tlb: begin
          if (tlb_cmd_done) begin
            s_axil_bvalid <= 1'b1;
            wr_state      <= w_resp;
          end
        end
        default: begin // w_resp
          if (s_axil_bvalid && s_axil_bready) begin
            s_axil_bvalid  <= 1'b0;
            s_axil_awready <= 1'b1;
            wr_state       <= w_idle;
          end
        end
      endcase
    end
  end

  // read side
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      rd_state       <= r_idle;
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      case (rd_state)
        r_idle: begin
          s_axil_arready <= 1'b1;
          if (s_axil_arvalid && s_axil_arready) begin
            ar_idx         <= s_axil_araddr[reg_idx_lsb +: reg_idx_w];
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b1;
            rd_state       <= r_resp;
          end
        end
        default: begin // r_resp
          if (r_fire) begin
            s_axil_rvalid  <= 1'b0;
            s_axil_arready <= 1'b1;
            rd_state       <= r_idle;
          end
        end
      endcase
    end
  end

  // datapath state advances on the read-data transfer
  assign rd_done_len_rd = r_fire && (ar_idx == reg_dma_reads);
  assign rd_done_len_wr = r_fire && (ar_idx == reg_dma_writes);
  assign rd_done_debug  = r_fire && (ar_idx == reg_debug);

  // read data tracks live inputs while rvalid is up
  always_comb begin
    s_axil_rresp = resp_okay;
    case (ar_idx)
      reg_dma_reads:  s_axil_rdata = len_rd_word;
      reg_dma_writes: s_axil_rdata = len_wr_word;
      reg_debug: begin
        s_axil_rdata = debug_hit ? debug_word : '0;
        if (!debug_hit) s_axil_rresp = resp_slverr; // index out of range
      end
      default: begin
        s_axil_rdata = unmapped_rdata;
        s_axil_rresp = resp_slverr;
      end
    endcase
  end

endmodule

//--- rtl/tlb_cmd_packer.sv
// TLB command packer
`timescale 1ns/1ps

module tlb_cmd_packer (
  input  logic                                  user_clk,
  input  logic                                  user_aresetn,
  input  logic                                  tlb_word_wr,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] tlb_wdata,
  output logic                                  tlb_word_last,
  output logic                                  tlb_cmd_valid,
  input  logic                                  tlb_cmd_ready,
  output logic [dma_stats_pkg::tlb_cmd_w-1:0]   tlb_cmd_data,
  output logic                                  tlb_cmd_done
);
  import dma_regmap_pkg::*;
  import dma_stats_pkg::*;

  logic [2:0] word_cnt; // words collected so far

  assign tlb_word_last = (word_cnt == 3'(tlb_cmd_words - 1));
  assign tlb_cmd_done  = tlb_cmd_valid && tlb_cmd_ready;

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      word_cnt      <= '0;
      tlb_cmd_valid <= 1'b0;
    end else begin
      if (tlb_cmd_done) tlb_cmd_valid <= 1'b0;
      if (tlb_word_wr) begin
        if (tlb_word_last) begin
          word_cnt      <= '0;
          tlb_cmd_valid <= 1'b1; // command complete
        end else begin
          word_cnt <= word_cnt + 3'd1;
        end
      end
    end
  end

  // payload, no reset
  always_ff @(posedge user_clk) begin
    if (tlb_word_wr) begin
      if (tlb_word_last)
        tlb_cmd_data[tlb_cmd_w-1] <= tlb_wdata[0]; // only bit 0 of last word
      else
        tlb_cmd_data[word_cnt*axil_data_w +: axil_data_w] <= tlb_wdata;
    end
  end

endmodule

//--- rtl/length_readout.sv
// Length counter half readout
`timescale 1ns/1ps

module length_readout #(
  parameter bit gate_on_flush = 1'b0 // zero the word until reads are flushed
) (
  input  logic                                  user_clk,
  input  logic                                  user_aresetn,
  input  logic [dma_stats_pkg::len_w-1:0]       len_count,
  input  logic                                  flushed,
  input  logic                                  rd_done,
  output logic [dma_regmap_pkg::axil_data_w-1:0] word
);
  import dma_regmap_pkg::*;
  import dma_stats_pkg::*;

  localparam int upper_w = len_w - axil_data_w; // 16 bits in the upper half

  logic upper; // next read returns the upper half

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      upper <= 1'b0;
    end else if (rd_done) begin
      upper <= ~upper; // flips even when gated
    end
  end

  always_comb begin
    if (gate_on_flush && !flushed)
      word = '0;
    else if (upper)
      word = {{(axil_data_w - upper_w){1'b0}}, len_count[len_w-1 -: upper_w]};
    else
      word = len_count[axil_data_w-1:0];
  end

endmodule

//--- rtl/debug_counter_mux.sv
// Debug statistics round-robin mux
`timescale 1ns/1ps

module debug_counter_mux (
  input  logic                                  user_clk,
  input  logic                                  user_aresetn,
  input  logic [dma_stats_pkg::stat_w-1:0]      write_cmd,
  input  logic [dma_stats_pkg::stat_w-1:0]      write_word,
  input  logic [dma_stats_pkg::stat_w-1:0]      write_pkg,
  input  logic [dma_stats_pkg::stat_w-1:0]      write_len,
  input  logic [dma_stats_pkg::stat_w-1:0]      read_cmd,
  input  logic [dma_stats_pkg::stat_w-1:0]      read_word,
  input  logic [dma_stats_pkg::stat_w-1:0]      read_pkg,
  input  logic [dma_stats_pkg::stat_w-1:0]      read_len,
  input  logic [dma_stats_pkg::stat_w-1:0]      tlb_miss,
  input  logic [dma_stats_pkg::stat_w-1:0]      tlb_page_cross,
  input  logic                                  rd_done,
  output logic [dma_regmap_pkg::axil_data_w-1:0] word,
  output logic                                  debug_hit
);
  import dma_regmap_pkg::*;
  import dma_stats_pkg::*;

  debug_sel_e idx; // counter returned by the next debug read

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      idx <= dbg_write_cmd;
    end else if (rd_done) begin
      if (idx == dbg_tlb_page_cross) idx <= dbg_write_cmd; // wrap
      else                           idx <= debug_sel_e'(idx + 4'd1);
    end
  end

  assign debug_hit = (int'(idx) < num_debug_regs);

  always_comb begin
    case (idx)
      dbg_write_cmd:      word = axil_data_w'(write_cmd);
      dbg_write_word:     word = axil_data_w'(write_word);
      dbg_write_pkg:      word = axil_data_w'(write_pkg);
      dbg_write_len:      word = axil_data_w'(write_len);
      dbg_read_cmd:       word = axil_data_w'(read_cmd);
      dbg_read_word:      word = axil_data_w'(read_word);
      dbg_read_pkg:       word = axil_data_w'(read_pkg);
      dbg_read_len:       word = axil_data_w'(read_len);
      dbg_tlb_miss:       word = axil_data_w'(tlb_miss);
      dbg_tlb_page_cross: word = axil_data_w'(tlb_page_cross);
      default:            word = '0; // miss
    endcase
  end

endmodule

//--- rtl/dma_controller.sv
// DMA controller top level
`timescale 1ns/1ps

module dma_controller #(
  parameter bit len_rd_gate = 1'b1, // read length gated by flush
  parameter bit len_wr_gate = 1'b0
) (
  input  logic                                  user_clk,
  input  logic                                  user_aresetn,
  input  logic [dma_regmap_pkg::axil_addr_w-1:0] s_axil_awaddr,
  input  logic                                  s_axil_awvalid,
  output logic                                  s_axil_awready,
  input  logic [dma_regmap_pkg::axil_data_w-1:0] s_axil_wdata,
  input  logic                                  s_axil_wvalid,
  output logic                                  s_axil_wready,
  output logic [1:0]                            s_axil_bresp,
  output logic                                  s_axil_bvalid,
  input  logic                                  s_axil_bready,
  input  logic [dma_regmap_pkg::axil_addr_w-1:0] s_axil_araddr,
  input  logic                                  s_axil_arvalid,
  output logic                                  s_axil_arready,
  output logic [dma_regmap_pkg::axil_data_w-1:0] s_axil_rdata,
  output logic [1:0]                            s_axil_rresp,
  output logic                                  s_axil_rvalid,
  input  logic                                  s_axil_rready,
  output logic                                  tlb_cmd_valid,
  input  logic                                  tlb_cmd_ready,
  output logic [dma_stats_pkg::tlb_cmd_w-1:0]   tlb_cmd_data,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_write_cmd_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_write_word_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_write_pkg_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_read_cmd_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_read_word_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      dma_read_pkg_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      tlb_miss_counter,
  input  logic [dma_stats_pkg::stat_w-1:0]      tlb_boundary_crossing_counter,
  input  logic [dma_stats_pkg::len_w-1:0]       dma_write_length_counter,
  input  logic [dma_stats_pkg::len_w-1:0]       dma_read_length_counter,
  input  logic                                  dma_reads_flushed,
  output logic                                  reset_dma_read_length_counter,
  output logic                                  reset_dma_write_length_counter
);
  import dma_regmap_pkg::*;
  import dma_stats_pkg::*;

  logic                   tlb_word_wr;   // word strobe into packer
  logic [axil_data_w-1:0] tlb_wdata;
  logic                   tlb_word_last; // next word closes a command
  logic                   tlb_cmd_done;
  logic                   rd_done_len_rd;
  logic                   rd_done_len_wr;
  logic                   rd_done_debug;
  logic [axil_data_w-1:0] len_rd_word;
  logic [axil_data_w-1:0] len_wr_word;
  logic [axil_data_w-1:0] debug_word;
  logic                   debug_hit;

  axil_ctrl_fsm ctrl_inst (.*);

  tlb_cmd_packer packer_inst (.*);

  length_readout #(.gate_on_flush(len_rd_gate)) len_rd_inst (
    .user_clk, .user_aresetn,
    .len_count (dma_read_length_counter),
    .flushed   (dma_reads_flushed),
    .rd_done   (rd_done_len_rd),
    .word      (len_rd_word)
  );

  length_readout #(.gate_on_flush(len_wr_gate)) len_wr_inst (
    .user_clk, .user_aresetn,
    .len_count (dma_write_length_counter),
    .flushed   (dma_reads_flushed), // only read when gated
    .rd_done   (rd_done_len_wr),
    .word      (len_wr_word)
  );

  debug_counter_mux debug_inst (
    .user_clk, .user_aresetn,
    .write_cmd      (dma_write_cmd_counter),
    .write_word     (dma_write_word_counter),
    .write_pkg      (dma_write_pkg_counter),
    .write_len      (dma_write_length_counter[stat_w-1:0]), // low half only
    .read_cmd       (dma_read_cmd_counter),
    .read_word      (dma_read_word_counter),
    .read_pkg       (dma_read_pkg_counter),
    .read_len       (dma_read_length_counter[stat_w-1:0]),
    .tlb_miss       (tlb_miss_counter),
    .tlb_page_cross (tlb_boundary_crossing_counter),
    .rd_done        (rd_done_debug),
    .word           (debug_word),
    .debug_hit
  );

endmodule

//--- bench/dma_controller_checker.sv
// DMA controller handshake assertions
`timescale 1ns/1ps

module dma_controller_checker (
  input logic user_clk,
  input logic user_aresetn,
  input logic s_axil_bvalid,
  input logic s_axil_bready,
  input logic s_axil_rvalid,
  input logic s_axil_rready,
  input logic tlb_cmd_valid,
  input logic tlb_cmd_ready,
  input logic reset_dma_read_length_counter,
  input logic reset_dma_write_length_counter
);

  int assert_fails = 0; // failure tally, summed into the final count

  a_bvalid_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      assert_fails++;
      $error("bvalid dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else begin
      assert_fails++;
      $error("rvalid dropped before rready");
    end

  a_cmd_hold: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    tlb_cmd_valid && !tlb_cmd_ready |=> tlb_cmd_valid)
    else begin
      assert_fails++;
      $error("tlb command valid dropped before ready");
    end

  // length resets are single-cycle pulses
  a_rd_strobe: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    reset_dma_read_length_counter |=> !reset_dma_read_length_counter)
    else begin
      assert_fails++;
      $error("read length reset strobe longer than one cycle");
    end

  a_wr_strobe: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    reset_dma_write_length_counter |=> !reset_dma_write_length_counter)
    else begin
      assert_fails++;
      $error("write length reset strobe longer than one cycle");
    end

endmodule

//--- bench/dma_controller_tb.sv
// DMA controller testbench
`timescale 1ns/1ps

module dma_controller_tb;
  import dma_regmap_pkg::*;
  import dma_stats_pkg::*;

  localparam int wait_limit = 64; // cycles allowed per handshake wait

  logic user_clk = 1'b0;
  logic user_aresetn;
  logic [axil_addr_w-1:0] s_axil_awaddr, s_axil_araddr;
  logic [axil_data_w-1:0] s_axil_wdata, s_axil_rdata;
  logic [1:0] s_axil_bresp, s_axil_rresp;
  logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic s_axil_rvalid, s_axil_rready;
  logic tlb_cmd_valid, tlb_cmd_ready;
  logic [tlb_cmd_w-1:0] tlb_cmd_data;
  logic [stat_w-1:0] dma_write_cmd_counter, dma_write_word_counter, dma_write_pkg_counter;
  logic [stat_w-1:0] dma_read_cmd_counter, dma_read_word_counter, dma_read_pkg_counter;
  logic [stat_w-1:0] tlb_miss_counter, tlb_boundary_crossing_counter;
  logic [len_w-1:0] dma_write_length_counter, dma_read_length_counter;
  logic dma_reads_flushed;
  logic reset_dma_read_length_counter, reset_dma_write_length_counter;

  int errors = 0;
  bit timed_out = 1'b0;
  int cmd_count = 0;              // command transfers seen
  int rd_strobes = 0;             // read length reset cycles seen
  int wr_strobes = 0;
  logic [tlb_cmd_w-1:0] cmd_seen; // payload of the last command
  int tlb_words = 0;              // words collected by the model
  bit rd_upper = 1'b0;            // next half expected from each length
  bit wr_upper = 1'b0;
  int dbg_idx = 0;                // next debug counter in the model

  dma_controller dut0 (.*);

  bind dma_controller dma_controller_checker checker_inst (.*);

  always #4 user_clk = ~user_clk; // 8 ns period

  // transfer and strobe monitor
  always @(posedge user_clk) begin
    if (tlb_cmd_valid && tlb_cmd_ready) begin
      cmd_count <= cmd_count + 1;
      cmd_seen  <= tlb_cmd_data;
    end
    if (reset_dma_read_length_counter) rd_strobes <= rd_strobes + 1;
    if (reset_dma_write_length_counter) wr_strobes <= wr_strobes + 1;
  end

  initial begin
    wait (timed_out);
    $display("run stopped on a handshake timeout, errors: %0d", errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("no %s within %0d cycles", what, wait_limit);
    timed_out = 1'b1;
  endtask

  task automatic randomize_stats();
    dma_write_cmd_counter         = $urandom;
    dma_write_word_counter        = $urandom;
    dma_write_pkg_counter         = $urandom;
    dma_read_cmd_counter          = $urandom;
    dma_read_word_counter         = $urandom;
    dma_read_pkg_counter          = $urandom;
    tlb_miss_counter              = $urandom;
    tlb_boundary_crossing_counter = $urandom;
    dma_write_length_counter      = {16'($urandom), 32'($urandom)};
    dma_read_length_counter       = {16'($urandom), 32'($urandom)};
  endtask

  // lower word or zero-extended upper 16 bits
  function automatic logic [31:0] half_of(input logic [len_w-1:0] count, input bit upper);
    return upper ? {16'd0, count[47:32]} : count[31:0];
  endfunction

  function automatic logic [31:0] debug_expected(input int idx);
    case (idx)
      0: return dma_write_cmd_counter;
      1: return dma_write_word_counter;
      2: return dma_write_pkg_counter;
      3: return dma_write_length_counter[31:0];
      4: return dma_read_cmd_counter;
      5: return dma_read_word_counter;
      6: return dma_read_pkg_counter;
      7: return dma_read_length_counter[31:0];
      8: return tlb_miss_counter;
      default: return tlb_boundary_crossing_counter;
    endcase
  endfunction

  task automatic write_req(input logic [reg_idx_w-1:0] idx, input logic [31:0] data);
    int n;
    s_axil_awaddr  = axil_addr_w'(idx) << reg_idx_lsb;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wvalid  = 1'b1;
    n = 0;
    while (!s_axil_awready && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_awready) report_timeout("awready");
    @(negedge user_clk); // address taken
    s_axil_awvalid = 1'b0;
    n = 0;
    while (!s_axil_wready && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_wready) report_timeout("wready");
    @(negedge user_clk); // data taken
    s_axil_wvalid = 1'b0;
  endtask

  task automatic write_resp(output logic [1:0] resp);
    int n;
    n = 0;
    while (!s_axil_bvalid && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_bvalid) report_timeout("bvalid");
    repeat ($urandom_range(3, 1)) @(negedge user_clk); // bready back-pressure
    resp = s_axil_bresp;
    s_axil_bready = 1'b1;
    @(negedge user_clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic write_reg(input logic [reg_idx_w-1:0] idx, input logic [31:0] data,
                           input string name);
    logic [1:0] resp;
    write_req(idx, data);
    write_resp(resp);
    compare_value(name, resp_okay, resp);
  endtask

  task automatic read_reg(input logic [reg_idx_w-1:0] idx, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    s_axil_araddr  = axil_addr_w'(idx) << reg_idx_lsb;
    s_axil_arvalid = 1'b1;
    n = 0;
    while (!s_axil_arready && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_arready) report_timeout("arready");
    @(negedge user_clk);
    s_axil_arvalid = 1'b0;
    n = 0;
    while (!s_axil_rvalid && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_rvalid) report_timeout("rvalid");
    repeat ($urandom_range(3, 1)) @(negedge user_clk); // rready back-pressure
    data = s_axil_rdata;
    resp = s_axil_rresp;
    s_axil_rready = 1'b1;
    @(negedge user_clk);
    s_axil_rready = 1'b0;
  endtask

  initial begin
    logic [31:0] words [tlb_cmd_words];
    logic [tlb_cmd_w-1:0] exp_cmd;
    logic [31:0] rdata;
    logic [31:0] exp_word;
    logic [1:0] resp;
    logic [reg_idx_w-1:0] idx;
    int n, base, base_rd, base_wr;
    void'($urandom(32'h90774c70));
    user_aresetn   = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    tlb_cmd_ready  = 1'b0;
    dma_reads_flushed = 1'b1;
    randomize_stats();
    repeat (2) @(posedge user_clk);
    @(negedge user_clk);
    user_aresetn = 1'b1;

    // outputs quiet after reset
    compare_value("reset bvalid", 0, s_axil_bvalid);
    compare_value("reset rvalid", 0, s_axil_rvalid);
    compare_value("reset cmd valid", 0, tlb_cmd_valid);
    compare_value("reset read strobe", 0, reset_dma_read_length_counter);
    compare_value("reset write strobe", 0, reset_dma_write_length_counter);
    n = 0;
    while (!s_axil_awready && n < wait_limit) begin
      @(negedge user_clk);
      n++;
    end
    if (!s_axil_awready) report_timeout("awready after reset");

    // two tlb commands under back-pressure
    for (int c = 0; c < 2; c++) begin
      base = cmd_count;
      exp_cmd = '0;
      foreach (words[i]) words[i] = $urandom;
      for (int i = 0; i < tlb_cmd_words - 1; i++) begin
        exp_cmd[tlb_words*32 +: 32] = words[i];
        write_reg(reg_tlb, words[i], "tlb word bresp");
        compare_value("no early command", 0, tlb_cmd_valid);
        tlb_words++;
      end
      exp_cmd[128] = words[4][0]; // only bit 0 of the last word
      write_req(reg_tlb, words[4]);
      tlb_words = 0;
      repeat ($urandom_range(8, 1)) begin
        compare_value("cmd valid held", 1, tlb_cmd_valid);
        compare_value("bvalid before command", 0, s_axil_bvalid);
        @(negedge user_clk);
      end
      tlb_cmd_ready = 1'b1;
      n = 0;
      while (cmd_count == base && n < wait_limit) begin
        compare_value("bvalid before command", 0, s_axil_bvalid);
        @(negedge user_clk);
        n++;
      end
      if (cmd_count == base) report_timeout("command transfer");
      compare_value("tlb command data", exp_cmd, cmd_seen);
      write_resp(resp);
      compare_value("last tlb word bresp", resp_okay, resp);
      repeat (2) @(negedge user_clk);
      compare_value("one command", base + 1, cmd_count);
      tlb_cmd_ready = 1'b0;
    end

    // length counter reset strobes
    base_rd = rd_strobes;
    base_wr = wr_strobes;
    write_reg(reg_dma_reads, $urandom, "read length reset bresp");
    repeat (2) @(negedge user_clk);
    compare_value("read strobe count", base_rd + 1, rd_strobes);
    compare_value("write strobe idle", base_wr, wr_strobes);
    write_reg(reg_dma_writes, $urandom, "write length reset bresp");
    repeat (2) @(negedge user_clk);
    compare_value("write strobe count", base_wr + 1, wr_strobes);
    compare_value("read strobe idle", base_rd + 1, rd_strobes);

    // alternating halves with the read side gated while not flushed
    for (int i = 0; i < 8; i++) begin
      randomize_stats();
      dma_reads_flushed = !(i == 2 || i == 3 || i == 5);
      read_reg(reg_dma_reads, rdata, resp);
      exp_word = dma_reads_flushed ? half_of(dma_read_length_counter, rd_upper) : 32'd0;
      compare_value("read length word", exp_word, rdata);
      compare_value("read length rresp", resp_okay, resp);
      rd_upper = !rd_upper; // advances even when gated
      read_reg(reg_dma_writes, rdata, resp);
      compare_value("write length word", half_of(dma_write_length_counter, wr_upper), rdata);
      compare_value("write length rresp", resp_okay, resp);
      wr_upper = !wr_upper;
    end
    dma_reads_flushed = 1'b1;

    // debug round-robin with wrap
    randomize_stats();
    for (int i = 0; i < 12; i++) begin
      read_reg(reg_debug, rdata, resp);
      compare_value("debug word", debug_expected(dbg_idx), rdata);
      compare_value("debug rresp", resp_okay, resp);
      dbg_idx = (dbg_idx + 1) % num_debug_regs;
    end

    // unmapped index
    do idx = reg_idx_w'($urandom_range(127, 0));
    while (idx == reg_tlb || idx == reg_dma_reads || idx == reg_dma_writes || idx == reg_debug);
    read_reg(idx, rdata, resp);
    compare_value("unmapped rdata", unmapped_rdata, rdata);
    compare_value("unmapped rresp", resp_slverr, resp);
    base = cmd_count;
    base_rd = rd_strobes;
    base_wr = wr_strobes;
    tlb_cmd_ready = 1'b1; // a stray command would transfer and be counted
    write_reg(idx, $urandom, "unmapped bresp");
    repeat (2) @(negedge user_clk);
    compare_value("unmapped read strobe", base_rd, rd_strobes);
    compare_value("unmapped write strobe", base_wr, wr_strobes);
    compare_value("unmapped command", base, cmd_count);
    compare_value("unmapped cmd valid", 0, tlb_cmd_valid);
    tlb_cmd_ready = 1'b0;

    repeat (2) @(negedge user_clk);
    errors += dut0.checker_inst.assert_fails;
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- dma_controller.f
rtl/dma_regmap_pkg.sv
rtl/dma_stats_pkg.sv
rtl/axil_ctrl_fsm.sv
rtl/tlb_cmd_packer.sv
rtl/length_readout.sv
rtl/debug_counter_mux.sv
rtl/dma_controller.sv
bench/dma_controller_checker.sv
bench/dma_controller_tb.sv
